/* Makefile */
TOP := cdc_bridge_tb

.PHONY: sim clean

# pass or fail is taken from the simulation output.
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cdc_bridge.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

/* cdc_bridge.f */
+incdir+logic
logic/cdc_ptr_pkg.sv
logic/bridge_msg_pkg.sv
logic/dual_port_ram.sv
logic/gray_ptr_sync.sv
logic/fifo_read_port.sv
logic/async_fifo.sv
logic/reg_bank_target.sv
logic/cdc_bridge.sv
tests/cdc_bridge_sva.sv
tests/cdc_bridge_tb.sv

/* logic/async_fifo.sv */
`timescale 1ns/10ps
`include "cdc_bridge_settings.svh"

module async_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input logic wclk,
	input logic wrstn,
	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,
	input logic rclk,
	input logic rrstn,
	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	localparam int AW = $bits(cdc_ptr_pkg::fifo_addr_t);

	// ********************
	// write domain
	// ********************

	cdc_ptr_pkg::fifo_ptr_t w_bin;
	cdc_ptr_pkg::fifo_ptr_t w_gray_now;  // Gray form of the live write pointer.
	cdc_ptr_pkg::fifo_ptr_t w_gray;      // registered copy that crosses over.
	cdc_ptr_pkg::fifo_ptr_t r_gray;      // the read side's registered copy.
	cdc_ptr_pkg::fifo_ptr_t r_gray_sync;
	logic w_live;
	logic wfull;
	logic wen;

	assign w_gray_now = w_bin ^ (w_bin >> 1);

	// full when the write side is one lap ahead of the read side.
	assign wfull = (w_gray_now == {~r_gray_sync[AW:AW-1], r_gray_sync[AW-2:0]});

	assign in_ready = w_live && !wfull;
	assign wen = in_valid && in_ready;

	// holds the write port closed for the first edge after reset.
	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			w_live <= 1'b0;
		end else begin
			w_live <= 1'b1;
		end
	end

	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			w_bin <= '0;
			w_gray <= '0;
		end else begin
			if (wen) begin
				w_bin <= w_bin + 1'b1;
			end
			w_gray <= w_gray_now;
		end
	end

	gray_ptr_sync i_rptr_sync (
		.clk(wclk),
		.rstn(wrstn),
		.ptr_in(r_gray),
		.ptr_out(r_gray_sync)
	);

	// ********************
	// read domain
	// ********************

	cdc_ptr_pkg::fifo_ptr_t r_bin;
	cdc_ptr_pkg::fifo_ptr_t r_gray_now;
	cdc_ptr_pkg::fifo_ptr_t w_gray_sync;
	logic rempty;
	logic ren;
	payload_t ram_data;

	assign r_gray_now = r_bin ^ (r_bin >> 1);
	assign rempty = (r_gray_now == w_gray_sync);

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			r_bin <= '0;
			r_gray <= '0;
		end else begin
			if (ren) begin
				r_bin <= r_bin + 1'b1;  // ren is only raised while not empty.
			end
			r_gray <= r_gray_now;
		end
	end

	gray_ptr_sync i_wptr_sync (
		.clk(rclk),
		.rstn(rrstn),
		.ptr_in(w_gray),
		.ptr_out(w_gray_sync)
	);

	// ********************
	// storage
	// ********************

	dual_port_ram #(
		.payload_t(payload_t),
		.DEPTH(`CDC_FIFO_DEPTH)
	) i_ram (
		.wclk(wclk),
		.wen(wen),
		.waddr(w_bin[AW-1:0]),
		.wdata(in_data),
		.rclk(rclk),
		.ren(ren),
		.raddr(r_bin[AW-1:0]),
		.rdata(ram_data)
	);

	fifo_read_port #(
		.payload_t(payload_t)
	) i_read_port (
		.rclk(rclk),
		.rrstn(rrstn),
		.empty(rempty),
		.ren(ren),
		.ram_data(ram_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

endmodule

/* logic/bridge_msg_pkg.sv */
`include "cdc_bridge_settings.svh"

package bridge_msg_pkg;

	// ********************
	// request, initiator to bank
	// ********************

	typedef struct packed {
		logic write;                       // high for a write, low for a read.
		cdc_ptr_pkg::reg_addr_t addr;
		logic [`CDC_DATA_WIDTH-1:0] wdata;  // ignored by the bank on a read.
	} req_msg_t;

	// ********************
	// response, bank to initiator
	// ********************

	// a write echoes its data, a read returns the stored value.
	typedef struct packed {
		logic write;
		cdc_ptr_pkg::reg_addr_t addr;
		logic [`CDC_DATA_WIDTH-1:0] rdata;
	} rsp_msg_t;

endpackage

/* logic/cdc_bridge.sv */
`timescale 1ns/10ps
`include "cdc_bridge_settings.svh"

module cdc_bridge (
	input logic wclk,
	input logic wrstn,
	input logic rclk,
	input logic rrstn,
	input logic req_valid,
	output logic req_ready,
	input logic req_write,
	input cdc_ptr_pkg::reg_addr_t req_addr,
	input logic [`CDC_DATA_WIDTH-1:0] req_wdata,
	output logic rsp_valid,
	input logic rsp_ready,
	output logic rsp_write,
	output cdc_ptr_pkg::reg_addr_t rsp_addr,
	output logic [`CDC_DATA_WIDTH-1:0] rsp_rdata
);

	bridge_msg_pkg::req_msg_t req_in;
	bridge_msg_pkg::req_msg_t req_out;
	bridge_msg_pkg::rsp_msg_t rsp_in;
	bridge_msg_pkg::rsp_msg_t rsp_out;
	logic bank_req_valid;
	logic bank_req_ready;
	logic bank_rsp_valid;
	logic bank_rsp_ready;

	assign req_in = '{write: req_write, addr: req_addr, wdata: req_wdata};

	assign rsp_write = rsp_out.write;
	assign rsp_addr = rsp_out.addr;
	assign rsp_rdata = rsp_out.rdata;

	// ********************
	// wclk to rclk
	// ********************

	async_fifo #(
		.payload_t(bridge_msg_pkg::req_msg_t)
	) i_req_fifo (
		.wclk(wclk),
		.wrstn(wrstn),
		.in_valid(req_valid),
		.in_ready(req_ready),
		.in_data(req_in),
		.rclk(rclk),
		.rrstn(rrstn),
		.out_valid(bank_req_valid),
		.out_ready(bank_req_ready),
		.out_data(req_out)
	);

	reg_bank_target i_bank (
		.rclk(rclk),
		.rrstn(rrstn),
		.req_valid(bank_req_valid),
		.req_ready(bank_req_ready),
		.req(req_out),
		.rsp_valid(bank_rsp_valid),
		.rsp_ready(bank_rsp_ready),
		.rsp(rsp_in)
	);

	// ********************
	// rclk back to wclk
	// ********************

	// the FIFO's write side runs on the target clock here.
	async_fifo #(
		.payload_t(bridge_msg_pkg::rsp_msg_t)
	) i_rsp_fifo (
		.wclk(rclk),
		.wrstn(rrstn),
		.in_valid(bank_rsp_valid),
		.in_ready(bank_rsp_ready),
		.in_data(rsp_in),
		.rclk(wclk),
		.rrstn(wrstn),
		.out_valid(rsp_valid),
		.out_ready(rsp_ready),
		.out_data(rsp_out)
	);

endmodule

/* logic/cdc_bridge_settings.svh */
`ifndef CDC_BRIDGE_SETTINGS_SVH
`define CDC_BRIDGE_SETTINGS_SVH

// ********************
// bridge sizing
// ********************

// entries in each FIFO, a power of two and at least four.
`define CDC_FIFO_DEPTH 8

// registers in the target bank.
`define CDC_REG_COUNT 16

// width of one register and of the data fields in both messages.
`define CDC_DATA_WIDTH 16

`endif

/* logic/cdc_ptr_pkg.sv */
`include "cdc_bridge_settings.svh"

package cdc_ptr_pkg;

	// ********************
	// widths
	// ********************

	localparam int FIFO_AW = $clog2(`CDC_FIFO_DEPTH);  // bits of RAM address.
	localparam int REG_AW = $clog2(`CDC_REG_COUNT);

	// ********************
	// types
	// ********************

	typedef logic [FIFO_AW-1:0] fifo_addr_t;

	// the extra top bit tells a full FIFO from an empty one.
	typedef logic [FIFO_AW:0] fifo_ptr_t;

	typedef logic [REG_AW-1:0] reg_addr_t;

endpackage

/* logic/dual_port_ram.sv */
`timescale 1ns/10ps
`include "cdc_bridge_settings.svh"

module dual_port_ram #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = `CDC_FIFO_DEPTH
) (
	input logic wclk,
	input logic wen,
	input cdc_ptr_pkg::fifo_addr_t waddr,
	input payload_t wdata,
	input logic rclk,
	input logic ren,
	input cdc_ptr_pkg::fifo_addr_t raddr,
	output payload_t rdata
);

	payload_t mem [DEPTH];

	// write port, owned by the producer clock.
	always_ff @(posedge wclk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// the read register keeps its word until the next enabled read.
	always_ff @(posedge rclk) begin
		if (ren) begin
			rdata <= mem[raddr];
		end
	end

endmodule

/* logic/fifo_read_port.sv */
`timescale 1ns/10ps

module fifo_read_port #(
	parameter type payload_t = logic [7:0]
) (
	input logic rclk,
	input logic rrstn,
	input logic empty,
	output logic ren,
	input payload_t ram_data,
	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	logic rd_pending;  // the RAM read register holds a word not yet taken.
	logic hold_valid;
	payload_t hold_data;
	logic pop;
	logic load;

	// ********************
	// handshake
	// ********************

	assign out_valid = hold_valid;
	assign out_data = hold_data;
	assign pop = hold_valid && out_ready;

	// the word in the RAM register moves on when the holding register frees.
	assign load = rd_pending && (!hold_valid || pop);

	// a new read may only replace a word that has already moved on.
	assign ren = !empty && (!rd_pending || !hold_valid || pop);

	// ********************
	// state
	// ********************

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			rd_pending <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			if (ren) begin
				rd_pending <= 1'b1;
			end else if (load) begin
				rd_pending <= 1'b0;
			end
			if (load) begin
				hold_valid <= 1'b1;
			end else if (pop) begin
				hold_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge rclk) begin
		if (load) begin
			hold_data <= ram_data;
		end
	end

endmodule

/* logic/gray_ptr_sync.sv */
`timescale 1ns/10ps

module gray_ptr_sync (
	input logic clk,
	input logic rstn,
	input cdc_ptr_pkg::fifo_ptr_t ptr_in,
	output cdc_ptr_pkg::fifo_ptr_t ptr_out
);

	// ********************
	// two flop synchronizer
	// ********************

	// only one bit of a Gray pointer moves per step, so a late sample
	// lands on either the old or the new value.
	cdc_ptr_pkg::fifo_ptr_t meta;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			meta <= '0;
			ptr_out <= '0;
		end else begin
			meta <= ptr_in;      // may go metastable.
			ptr_out <= meta;
		end
	end

endmodule

/* logic/reg_bank_target.sv */
`timescale 1ns/10ps
`include "cdc_bridge_settings.svh"

module reg_bank_target (
	input logic rclk,
	input logic rrstn,
	input logic req_valid,
	output logic req_ready,
	input bridge_msg_pkg::req_msg_t req,
	output logic rsp_valid,
	input logic rsp_ready,
	output bridge_msg_pkg::rsp_msg_t rsp
);

	logic [`CDC_DATA_WIDTH-1:0] regs [`CDC_REG_COUNT];
	logic accept;

	// one request at a time, the next waits for the response to leave.
	assign req_ready = !rsp_valid;
	assign accept = req_valid && req_ready;

	// ********************
	// register file
	// ********************

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			for (int i = 0; i < `CDC_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (accept && req.write) begin
			regs[req.addr] <= req.wdata;
		end
	end

	// ********************
	// response
	// ********************

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			rsp_valid <= 1'b0;
		end else if (accept) begin
			rsp_valid <= 1'b1;
		end else if (rsp_ready) begin
			rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge rclk) begin
		if (accept) begin
			rsp.write <= req.write;
			rsp.addr <= req.addr;
			rsp.rdata <= req.write ? req.wdata : regs[req.addr];  // read sees the old value.
		end
	end

endmodule

/* tests/cdc_bridge_sva.sv */
`timescale 1ns/10ps
`include "cdc_bridge_settings.svh"

module cdc_bridge_sva (
	input logic wclk,
	input logic wrstn,
	input logic req_valid,
	input logic req_ready,
	input logic req_write,
	input cdc_ptr_pkg::reg_addr_t req_addr,
	input logic [`CDC_DATA_WIDTH-1:0] req_wdata,
	input logic rsp_valid,
	input logic rsp_ready,
	input logic rsp_write,
	input cdc_ptr_pkg::reg_addr_t rsp_addr,
	input logic [`CDC_DATA_WIDTH-1:0] rsp_rdata
);

	int sva_errors = 0;
	int req_count;  // requests taken at the external port.
	int rsp_count;

	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			req_count <= 0;
			rsp_count <= 0;
		end else begin
			if (req_valid && req_ready) begin
				req_count <= req_count + 1;
			end
			if (rsp_valid && rsp_ready) begin
				rsp_count <= rsp_count + 1;
			end
		end
	end

	// ********************
	// reset
	// ********************

	reset_quiet: assert property (@(posedge wclk) !wrstn |-> !req_ready && !rsp_valid)
		else begin
			$error("req_ready or rsp_valid is high while wrstn is low");
			sva_errors++;
		end

	ready_after_reset: assert property (@(posedge wclk) $rose(wrstn) |=> req_ready)
		else begin
			$error("req_ready did not rise one cycle after wrstn was released");
			sva_errors++;
		end

	// ********************
	// handshakes
	// ********************

	// a stalled response keeps its valid and its payload.
	rsp_stable: assert property (@(posedge wclk) disable iff (!wrstn)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_write) &&
		$stable(rsp_addr) && $stable(rsp_rdata))
		else begin
			$error("response ports changed while rsp_ready was low");
			sva_errors++;
		end

	req_stable: assert property (@(posedge wclk) disable iff (!wrstn)
		req_valid && !req_ready |=> req_valid && $stable(req_write) &&
		$stable(req_addr) && $stable(req_wdata))
		else begin
			$error("request ports changed while req_ready was low");
			sva_errors++;
		end

	// every response needs a request still outstanding.
	rsp_bounded: assert property (@(posedge wclk) disable iff (!wrstn)
		rsp_valid && rsp_ready |-> rsp_count < req_count)
		else begin
			$error("more responses than accepted requests");
			sva_errors++;
		end

endmodule

bind cdc_bridge cdc_bridge_sva i_sva (
	.wclk(wclk),
	.wrstn(wrstn),
	.req_valid(req_valid),
	.req_ready(req_ready),
	.req_write(req_write),
	.req_addr(req_addr),
	.req_wdata(req_wdata),
	.rsp_valid(rsp_valid),
	.rsp_ready(rsp_ready),
	.rsp_write(rsp_write),
	.rsp_addr(rsp_addr),
	.rsp_rdata(rsp_rdata)
);

/* tests/cdc_bridge_tb.sv */
`timescale 1ns/10ps
`include "cdc_bridge_settings.svh"

module cdc_bridge_tb;

	localparam int WCLK_NS = 14;
	localparam int BURST_LEN = 48;
	localparam int TOTAL_REQS = `CDC_REG_COUNT * 4 + BURST_LEN;
	localparam longint WATCHDOG_NS = longint'(TOTAL_REQS) * 200 * WCLK_NS;

	logic wclk, rclk, wrstn, rrstn;
	logic req_valid, req_ready, req_write;
	cdc_ptr_pkg::reg_addr_t req_addr;
	logic [`CDC_DATA_WIDTH-1:0] req_wdata;
	logic rsp_valid, rsp_ready, rsp_write;
	cdc_ptr_pkg::reg_addr_t rsp_addr;
	logic [`CDC_DATA_WIDTH-1:0] rsp_rdata;

	logic [`CDC_DATA_WIDTH-1:0] model_regs [`CDC_REG_COUNT];
	bridge_msg_pkg::rsp_msg_t exp_q [$];  // expected responses in request order.
	int seed, accepted, received, errors;
	logic saw_block, burst_done;

	cdc_bridge i_cdc_bridge (
		.wclk(wclk), .wrstn(wrstn), .rclk(rclk), .rrstn(rrstn),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_write(rsp_write),
		.rsp_addr(rsp_addr), .rsp_rdata(rsp_rdata)
	);

	always #5 rclk = ~rclk;
	always #(WCLK_NS / 2) wclk = ~wclk;

	task automatic check_response();
		bridge_msg_pkg::rsp_msg_t exp;
		assert (exp_q.size() > 0) else begin
			errors++;
			$display("Fail at %0t: response with no request outstanding", $time);
		end
		if (exp_q.size() > 0) begin
			exp = exp_q.pop_front();
			assert (rsp_write == exp.write && rsp_addr == exp.addr && rsp_rdata == exp.rdata)
			else begin
				errors++;
				$display("Fail at %0t: response %0d is w%0b a%0d d%h, expected w%0b a%0d d%h",
					$time, received, rsp_write, rsp_addr, rsp_rdata,
					exp.write, exp.addr, exp.rdata);
			end
		end
	endtask

	// reference model that follows the order of acceptance.
	always @(posedge wclk) begin : monitor
		bridge_msg_pkg::rsp_msg_t exp;
		if (wrstn && req_valid && req_ready) begin
			accepted++;
			exp.write = req_write;
			exp.addr = req_addr;
			exp.rdata = req_write ? req_wdata : model_regs[req_addr];
			if (req_write) begin
				model_regs[req_addr] = req_wdata;
			end
			exp_q.push_back(exp);
		end
		if (wrstn && req_valid && !req_ready) begin
			saw_block = 1'b1;
		end
		if (wrstn && rsp_valid && rsp_ready) begin
			received++;
			check_response();
		end
	end

	// starts on a wclk edge and returns on the edge where the request is taken.
	task automatic send_request(input logic write, input cdc_ptr_pkg::reg_addr_t addr,
			input logic [`CDC_DATA_WIDTH-1:0] data);
		req_valid <= 1'b1;
		req_write <= write;
		req_addr <= addr;
		req_wdata <= data;
		@(posedge wclk);
		while (!req_ready) begin
			@(posedge wclk);
		end
	endtask

	task automatic send_random(input logic write, input int addr);
		int rnd;
		rnd = $random(seed);
		send_request(write, cdc_ptr_pkg::reg_addr_t'(addr), rnd[`CDC_DATA_WIDTH-1:0]);
	endtask

	task automatic drain();
		req_valid <= 1'b0;
		@(posedge wclk);
		while (exp_q.size() != 0) begin
			@(posedge wclk);
		end
	endtask

	task automatic report_test(input string name, input int first_err);
		$display("%s finished with %0d errors", name, errors - first_err);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the bridge did not answer every request within %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	initial begin
		int mark;
		int rnd;
		seed = 23424;
		{rclk, wclk, wrstn, rrstn} = '0;
		{req_valid, req_write, req_addr, req_wdata, rsp_ready} = '0;
		{accepted, received, errors} = '0;
		{saw_block, burst_done} = '0;
		for (int i = 0; i < `CDC_REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		// each reset lets go between two edges of its own clock.
		fork
			begin
				repeat (3) @(posedge wclk);
				#3 wrstn <= 1'b1;
			end
			begin
				repeat (3) @(posedge rclk);
				#2 rrstn <= 1'b1;
			end
		join
		@(posedge wclk);
		rsp_ready <= 1'b1;

		mark = errors;
		for (int i = 0; i < `CDC_REG_COUNT; i++) begin
			send_random(1'b0, i);
		end
		drain();
		report_test("read after reset", mark);

		mark = errors;
		for (int i = 0; i < `CDC_REG_COUNT; i++) begin
			send_random(1'b1, i);
			send_random(1'b1, i);
			send_random(1'b0, i);
		end
		drain();
		report_test("write and read back", mark);

		// responses stall until the request side has backed up.
		mark = errors;
		saw_block = 1'b0;
		rsp_ready <= 1'b0;
		fork
			begin
				for (int i = 0; i < BURST_LEN; i++) begin
					rnd = $random(seed);
					send_random(rnd[4], rnd[2:0]);
				end
				req_valid <= 1'b0;
				burst_done = 1'b1;
			end
			begin
				wait (saw_block || burst_done);
				repeat (20) @(posedge wclk);
				rsp_ready <= 1'b1;
			end
		join
		drain();
		assert (saw_block) else begin
			errors++;
			$display("Fail at %0t: req_ready never fell with responses blocked", $time);
		end
		report_test("blocked burst", mark);

		assert (accepted == received && exp_q.size() == 0) else begin
			errors++;
			$display("Fail at %0t: %0d requests accepted, %0d responses", $time,
				accepted, received);
		end
		$display("%0d requests, %0d responses, %0d errors, %0d assertion failures",
			accepted, received, errors, i_cdc_bridge.i_sva.sva_errors);
		if (errors == 0 && i_cdc_bridge.i_sva.sva_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
